// File: axis_stream_pkg.sv
`default_nettype none

package axis_stream_pkg;

  // Data stream geometry
  localparam int AXIS_DATA_W = 32;
  localparam int AXIS_STRB_W = AXIS_DATA_W / 8;

  // One beat as it sits in the data slice
  typedef struct packed {
    logic [AXIS_DATA_W-1:0] data;
    logic [AXIS_STRB_W-1:0] strb;
    logic                   last;
  } axis_beat_t;

endpackage

`default_nettype wire

// File: packet_report_pkg.sv
`default_nettype none

package packet_report_pkg;

  localparam int RPT_SEQ_W  = 16; // Wraps after 64k packets
  localparam int RPT_LEN_W  = 8;
  localparam int RPT_CSUM_W = 32; // Same as the data word

  // One report per packet
  typedef struct packed {
    logic [RPT_SEQ_W-1:0]  seq;
    logic [RPT_LEN_W-1:0]  len;
    logic [RPT_CSUM_W-1:0] checksum;
  } packet_report_t;

endpackage

`default_nettype wire

// File: axis_pattern_master.sv
`timescale 1ns/1ns
`default_nettype none

module axis_pattern_master import axis_stream_pkg::*; #(
  parameter int start_count      = 32,
  parameter int words_per_packet = 8
) (
  input  logic                   M_AXIS_ACLK,
  input  logic                   M_AXIS_ARESETN,
  output logic                   gen_valid,
  output logic [AXIS_DATA_W-1:0] gen_data,
  output logic [AXIS_STRB_W-1:0] gen_strb,
  output logic                   gen_last,
  input  logic                   gen_ready
);

  localparam int cnt_w = $clog2(start_count);
  localparam int ptr_w = $clog2(words_per_packet + 1);

  typedef enum logic [1:0] {
    st_idle,
    st_wait,
    st_send
  } state_t;

  state_t                 state;
  logic [cnt_w-1:0]       wait_cnt;
  logic [ptr_w-1:0]       word_ptr;
  logic [AXIS_DATA_W-1:0] word_cnt;
  logic                   xfer;

  assign gen_valid = (state == st_send);
  assign gen_last  = (word_ptr == ptr_w'(words_per_packet - 1));
  assign gen_data  = ~word_cnt; // Inverted counter pattern
  assign gen_strb  = '1;
  assign xfer      = gen_valid && gen_ready;

  // Packet sequencing
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      state    <= st_idle;
      wait_cnt <= '0;
      word_ptr <= '0;
    end else begin
      case (state)
        st_idle: begin
          state    <= st_wait;
          wait_cnt <= '0;
        end
        st_wait: begin
          if (wait_cnt == cnt_w'(start_count - 1)) begin
            state <= st_send;
          end else begin
            wait_cnt <= wait_cnt + 1'b1;
          end
        end
        st_send: begin
          if (xfer) begin
            if (gen_last) begin
              state    <= st_idle; // One idle cycle, then wait again
              word_ptr <= '0;
            end else begin
              word_ptr <= word_ptr + 1'b1;
            end
          end
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Running word counter, never rewinds across packets
  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      word_cnt <= AXIS_DATA_W'(1);
    end else if (xfer) begin
      word_cnt <= word_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: axis_reg_slice.sv
`timescale 1ns/1ns
`default_nettype none

module axis_reg_slice #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     M_AXIS_ACLK,
  input  logic     M_AXIS_ARESETN,
  input  logic     s_valid,
  input  payload_t s_payload,
  output logic     s_ready,
  output logic     m_valid,
  output payload_t m_payload,
  input  logic     m_ready
);

  logic     skid_valid;
  payload_t skid_payload;
  logic     in_xfer;
  logic     main_free;

  // Ready comes straight from a flop
  assign s_ready   = ~skid_valid;
  assign in_xfer   = s_valid && s_ready;
  assign main_free = m_ready || !m_valid; // Main register drains or is empty

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      m_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      if (main_free) begin
        if (skid_valid) begin
          m_valid    <= 1'b1;
          skid_valid <= 1'b0;
        end else begin
          m_valid <= in_xfer;
        end
      end else if (in_xfer) begin
        skid_valid <= 1'b1; // Output blocked, park the beat
      end
    end
  end

  always_ff @(posedge M_AXIS_ACLK) begin
    if (main_free) begin
      if (skid_valid) begin
        m_payload <= skid_payload;
      end else if (in_xfer) begin
        m_payload <= s_payload;
      end
    end else if (in_xfer) begin
      skid_payload <= s_payload;
    end
  end

endmodule

`default_nettype wire

// File: axis_packet_monitor.sv
`timescale 1ns/1ns
`default_nettype none

module axis_packet_monitor import axis_stream_pkg::*; import packet_report_pkg::*; (
  input  logic                   M_AXIS_ACLK,
  input  logic                   M_AXIS_ARESETN,
  input  logic                   slc_valid,
  input  logic [AXIS_DATA_W-1:0] slc_data,
  input  logic [AXIS_STRB_W-1:0] slc_strb,
  input  logic                   slc_last,
  output logic                   slc_ready,
  output logic                   tvalid,
  output logic [AXIS_DATA_W-1:0] tdata,
  output logic [AXIS_STRB_W-1:0] tstrb,
  output logic                   tlast,
  input  logic                   tready,
  output logic                   rpt_in_valid,
  output packet_report_t         rpt_in,
  input  logic                   rpt_in_ready
);

  logic [RPT_SEQ_W-1:0]  seq;
  logic [RPT_LEN_W-1:0]  len_cnt;
  logic [RPT_CSUM_W-1:0] csum;
  logic                  out_xfer;

  // Pass-through, held off while a report is pending
  assign tvalid    = slc_valid && !rpt_in_valid;
  assign slc_ready = tready && !rpt_in_valid;
  assign tdata     = slc_data;
  assign tstrb     = slc_strb;
  assign tlast     = slc_last;
  assign out_xfer  = tvalid && tready;

  always_ff @(posedge M_AXIS_ACLK) begin
    if (!M_AXIS_ARESETN) begin
      seq          <= '0;
      len_cnt      <= '0;
      csum         <= '0;
      rpt_in_valid <= 1'b0;
    end else begin
      if (rpt_in_valid && rpt_in_ready) begin
        rpt_in_valid <= 1'b0;
      end
      if (out_xfer) begin
        if (slc_last) begin
          rpt_in_valid <= 1'b1;
          seq          <= seq + 1'b1;
          len_cnt      <= '0;
          csum         <= '0;
        end else begin
          len_cnt <= len_cnt + 1'b1;
          csum    <= csum ^ slc_data;
        end
      end
    end
  end

  // Report fields, captured with the closing beat
  always_ff @(posedge M_AXIS_ACLK) begin
    if (out_xfer && slc_last) begin
      rpt_in.seq      <= seq;
      rpt_in.len      <= len_cnt + 1'b1;
      rpt_in.checksum <= csum ^ slc_data;
    end
  end

endmodule

`default_nettype wire

// File: axis_packet_source_top.sv
`timescale 1ns/1ns
`default_nettype none

module axis_packet_source_top import axis_stream_pkg::*; import packet_report_pkg::*; #(
  parameter int start_count      = 32,
  parameter int words_per_packet = 8
) (
  input  logic                   M_AXIS_ACLK,
  input  logic                   M_AXIS_ARESETN,
  output logic                   tvalid,
  output logic [AXIS_DATA_W-1:0] tdata,
  output logic [AXIS_STRB_W-1:0] tstrb,
  output logic                   tlast,
  input  logic                   tready,
  output logic                   rpt_valid,
  output logic [RPT_SEQ_W-1:0]   rpt_seq,
  output logic [RPT_LEN_W-1:0]   rpt_len,
  output logic [RPT_CSUM_W-1:0]  rpt_checksum,
  input  logic                   rpt_ready
);

  logic                   gen_valid;
  logic [AXIS_DATA_W-1:0] gen_data;
  logic [AXIS_STRB_W-1:0] gen_strb;
  logic                   gen_last;
  logic                   gen_ready;
  logic                   slc_valid;
  axis_beat_t             slc_beat;
  logic                   slc_ready;
  logic                   rpt_in_valid;
  packet_report_t         rpt_in;
  logic                   rpt_in_ready;
  packet_report_t         rpt_out;

  axis_pattern_master #(
    .start_count      (start_count),
    .words_per_packet (words_per_packet)
  ) i_master (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .gen_valid      (gen_valid),
    .gen_data       (gen_data),
    .gen_strb       (gen_strb),
    .gen_last       (gen_last),
    .gen_ready      (gen_ready)
  );

  axis_reg_slice #(
    .payload_t (axis_beat_t)
  ) i_data_slice (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .s_valid        (gen_valid),
    .s_payload      (axis_beat_t'{data: gen_data, strb: gen_strb, last: gen_last}),
    .s_ready        (gen_ready),
    .m_valid        (slc_valid),
    .m_payload      (slc_beat),
    .m_ready        (slc_ready)
  );

  axis_packet_monitor i_monitor (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .slc_valid      (slc_valid),
    .slc_data       (slc_beat.data),
    .slc_strb       (slc_beat.strb),
    .slc_last       (slc_beat.last),
    .slc_ready      (slc_ready),
    .tvalid         (tvalid),
    .tdata          (tdata),
    .tstrb          (tstrb),
    .tlast          (tlast),
    .tready         (tready),
    .rpt_in_valid   (rpt_in_valid),
    .rpt_in         (rpt_in),
    .rpt_in_ready   (rpt_in_ready)
  );

  axis_reg_slice #(
    .payload_t (packet_report_t)
  ) i_rpt_slice (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .s_valid        (rpt_in_valid),
    .s_payload      (rpt_in),
    .s_ready        (rpt_in_ready),
    .m_valid        (rpt_valid),
    .m_payload      (rpt_out),
    .m_ready        (rpt_ready)
  );

  assign rpt_seq      = rpt_out.seq;
  assign rpt_len      = rpt_out.len;
  assign rpt_checksum = rpt_out.checksum;

endmodule

`default_nettype wire

// File: tb_axis_packet_source.sv
`timescale 1ns/1ns
`default_nettype none

module tb_axis_packet_source import axis_stream_pkg::*; import packet_report_pkg::*; ();

  localparam int start_count      = 32;
  localparam int words_per_packet = 8;
  localparam int n_reports        = 40;
  localparam int timeout_cycles   = n_reports * (start_count + words_per_packet + 2) * 4 + 200;
  localparam int rpt_path_depth   = 3; // Two in the report slice, one in the monitor

  logic                   M_AXIS_ACLK = 1'b0;
  logic                   M_AXIS_ARESETN;
  logic                   tvalid;
  logic [AXIS_DATA_W-1:0] tdata;
  logic [AXIS_STRB_W-1:0] tstrb;
  logic                   tlast;
  logic                   tready;
  logic                   rpt_valid;
  logic [RPT_SEQ_W-1:0]   rpt_seq;
  logic [RPT_LEN_W-1:0]   rpt_len;
  logic [RPT_CSUM_W-1:0]  rpt_checksum;
  logic                   rpt_ready;

  logic [AXIS_DATA_W-1:0] exp_word; // Model of the master's word counter
  logic [RPT_CSUM_W-1:0]  run_csum;
  int                     word_pos;
  logic [RPT_CSUM_W-1:0]  exp_csum_q[$]; // Finished packets awaiting their report
  int                     rpt_seen;
  int                     cyc;
  int                     value_errs;
  int                     other_errs;
  logic                   full_seen;

  logic [31:0]            lcg_state;
  int                     both_low_left;
  int                     rpt_hold_left;
  int                     holds_done;

  logic                   prev_tvalid;
  logic                   prev_tready;
  logic [AXIS_DATA_W-1:0] prev_tdata;
  logic                   prev_tlast;
  logic                   prev_rpt_valid;
  logic                   prev_rpt_ready;
  logic [RPT_SEQ_W-1:0]   prev_rpt_seq;
  logic [RPT_LEN_W-1:0]   prev_rpt_len;
  logic [RPT_CSUM_W-1:0]  prev_rpt_checksum;

  axis_packet_source_top #(
    .start_count      (start_count),
    .words_per_packet (words_per_packet)
  ) i_dut (
    .M_AXIS_ACLK    (M_AXIS_ACLK),
    .M_AXIS_ARESETN (M_AXIS_ARESETN),
    .tvalid         (tvalid),
    .tdata          (tdata),
    .tstrb          (tstrb),
    .tlast          (tlast),
    .tready         (tready),
    .rpt_valid      (rpt_valid),
    .rpt_seq        (rpt_seq),
    .rpt_len        (rpt_len),
    .rpt_checksum   (rpt_checksum),
    .rpt_ready      (rpt_ready)
  );

  always #10 M_AXIS_ACLK = ~M_AXIS_ACLK;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] exp, input logic [31:0] obs);
    value_errs++;
    $display("[ERROR] %s expected %h observed %h at cycle %0d", name, exp, obs, cyc);
  endtask

  task automatic flag_failure(input string what);
    other_errs++;
    $display("Check failed at cycle %0d: %s", cyc, what);
  endtask

  task automatic check_beat();
    logic [AXIS_DATA_W-1:0] exp_data;
    logic                   exp_last;
    exp_data = ~exp_word;
    exp_last = (word_pos == words_per_packet - 1);
    assert (tdata === exp_data) else flag_mismatch("tdata", exp_data, tdata);
    assert (tstrb === {AXIS_STRB_W{1'b1}})
      else flag_mismatch("tstrb", 32'({AXIS_STRB_W{1'b1}}), 32'(tstrb));
    assert (tlast === exp_last) else flag_mismatch("tlast", 32'(exp_last), 32'(tlast));
    run_csum = run_csum ^ exp_data;
    if (exp_last) begin
      exp_csum_q.push_back(run_csum);
      run_csum = '0;
      word_pos = 0;
    end else begin
      word_pos++;
    end
    exp_word = exp_word + 32'd1;
  endtask

  task automatic check_report();
    logic [RPT_CSUM_W-1:0] exp_csum;
    assert (exp_csum_q.size() > 0)
      else flag_failure("a report was accepted before its packet ended");
    if (exp_csum_q.size() > 0) begin
      exp_csum = exp_csum_q.pop_front();
      assert (rpt_checksum === exp_csum)
        else flag_mismatch("rpt_checksum", exp_csum, rpt_checksum);
    end
    assert (rpt_seq === RPT_SEQ_W'(rpt_seen))
      else flag_mismatch("rpt_seq", rpt_seen, 32'(rpt_seq));
    assert (rpt_len === RPT_LEN_W'(words_per_packet))
      else flag_mismatch("rpt_len", words_per_packet, 32'(rpt_len));
    rpt_seen++;
  endtask

  // Random back-pressure on both output streams
  always @(negedge M_AXIS_ACLK) begin
    lcg_state = lcg_next(lcg_state);
    if (both_low_left > 0) begin
      both_low_left--;
      tready    <= 1'b0;
      rpt_ready <= 1'b0;
    end else if (rpt_hold_left > 0) begin
      rpt_hold_left--; // Long enough for the report path to fill
      tready    <= (lcg_state[15:8] < 8'd179);
      rpt_ready <= 1'b0;
    end else if (holds_done < 2 && rpt_seen >= 12 + 13 * holds_done) begin
      holds_done++;
      rpt_hold_left = 240 + int'(lcg_state[4:0]);
      tready    <= (lcg_state[15:8] < 8'd179);
      rpt_ready <= 1'b0;
    end else if (lcg_state[31:26] == 6'd0) begin
      both_low_left = 4 + int'(lcg_state[3:0]);
      tready    <= 1'b0;
      rpt_ready <= 1'b0;
    end else begin
      tready    <= (lcg_state[15:8] < 8'd179); // About 70 %
      rpt_ready <= (lcg_state[23:16] < 8'd128);
    end
  end

  always @(posedge M_AXIS_ACLK) begin
    if (cyc >= 2 && cyc < 16 + start_count) begin
      assert (tvalid === 1'b0 && rpt_valid === 1'b0)
        else flag_failure("an output valid rose during reset or the start-up wait");
    end
    if (M_AXIS_ARESETN) begin
      if (prev_tvalid === 1'b1 && prev_tready === 1'b0) begin
        assert (tvalid === 1'b1 && tdata === prev_tdata && tlast === prev_tlast)
          else flag_failure("the data beat changed while tready was low");
      end
      if (prev_rpt_valid === 1'b1 && prev_rpt_ready === 1'b0) begin
        assert (rpt_valid === 1'b1 && rpt_seq === prev_rpt_seq && rpt_len === prev_rpt_len &&
                rpt_checksum === prev_rpt_checksum)
          else flag_failure("the report changed while rpt_ready was low");
      end
      assert (exp_csum_q.size() <= rpt_path_depth)
        else flag_failure("more reports are outstanding than the report path can hold");
      if (exp_csum_q.size() == rpt_path_depth) begin
        full_seen = 1'b1;
        assert (tvalid === 1'b0)
          else flag_failure("the stream kept going with the report path full");
      end
      if (tvalid === 1'b1 && tready === 1'b1) begin
        check_beat();
      end
      if (rpt_valid === 1'b1 && rpt_ready === 1'b1) begin
        check_report();
      end
    end
    prev_tvalid       = tvalid;
    prev_tready       = tready;
    prev_tdata        = tdata;
    prev_tlast        = tlast;
    prev_rpt_valid    = rpt_valid;
    prev_rpt_ready    = rpt_ready;
    prev_rpt_seq      = rpt_seq;
    prev_rpt_len      = rpt_len;
    prev_rpt_checksum = rpt_checksum;
    cyc++;
  end

  initial begin
    M_AXIS_ARESETN = 1'b0;
    tready         = 1'b0;
    rpt_ready      = 1'b0;
    lcg_state      = 32'h9c3d_31ba;
    exp_word       = 32'd1;
    run_csum       = '0;
    word_pos       = 0;
    rpt_seen       = 0;
    cyc            = 0;
    value_errs     = 0;
    other_errs     = 0;
    full_seen      = 1'b0;
    both_low_left  = 0;
    rpt_hold_left  = 0;
    holds_done     = 0;
    repeat (16) @(posedge M_AXIS_ACLK);
    @(negedge M_AXIS_ACLK);
    M_AXIS_ARESETN = 1'b1;
    while (rpt_seen < n_reports && cyc < timeout_cycles) begin
      @(negedge M_AXIS_ACLK);
    end
    assert (rpt_seen >= n_reports)
      else flag_failure($sformatf("timeout, only %0d of %0d reports arrived", rpt_seen, n_reports));
    assert (full_seen) else flag_failure("the report path never filled up during the run");
    $display("Done after %0d cycles: %0d reports, %0d value errors, %0d other errors",
             cyc, rpt_seen, value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
axis_stream_pkg.sv
packet_report_pkg.sv
axis_pattern_master.sv
axis_reg_slice.sv
axis_packet_monitor.sv
axis_packet_source_top.sv
tb_axis_packet_source.sv

// File: run.sh
#!/bin/sh
# Build and run the packet source testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f compile.f \
  --top-module tb_axis_packet_source \
  -o tb_sim

./obj_dir/tb_sim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Testbench reported a failure, see sim.log"
  exit 1
fi

echo "Run finished without a reported failure"
exit 0
